//--- rtl/udma_pkg.sv
// Shared address fields, register offsets and widths of the micro-DMA control plane
`default_nettype none

package udma_pkg;

    // APB slave window is 4 KB
    localparam int unsigned APB_ADDR_WIDTH = 12;

    // paddr[11:7] selects the target, paddr[6:2] the word inside it
    localparam int unsigned ID_LSB       = 7;
    localparam int unsigned ID_WIDTH     = 5;
    localparam int unsigned OFFSET_WIDTH = 5;

    // global control registers sit at the last target ID
    localparam logic [ID_WIDTH-1:0] CTRL_ID = 5'd31;

    // control register word offsets
    localparam logic [OFFSET_WIDTH-1:0] REG_CLK_EN  = 5'd0;
    // trigger k lives in byte k
    localparam logic [OFFSET_WIDTH-1:0] REG_TRIG_ID = 5'd1;

    // event side
    localparam int unsigned N_TRIGGERS   = 4;
    localparam int unsigned EVT_ID_WIDTH = 8;
    localparam int unsigned EVT_WIDTH    = 4;
    localparam int unsigned N_EVT_SLOTS  = 32;

endpackage

`default_nettype wire

//--- rtl/udma_apb_decoder.sv
// APB slave that splits the address, drives the peripheral config bus and muxes the responses
`timescale 1ns/1ps
`default_nettype none

module udma_apb_decoder #(
    parameter int N_PERIPHS = 6
) (
    input  wire logic                                  sys_clk_i,
    input  wire logic                                  rst_n_i,
    // APB slave
    input  wire logic [udma_pkg::APB_ADDR_WIDTH-1:0]   paddr_i,
    input  wire logic [31:0]                           pwdata_i,
    input  wire logic                                  pwrite_i,
    input  wire logic                                  psel_i,
    input  wire logic                                  penable_i,
    output logic      [31:0]                           prdata_o,
    output logic                                       pready_o,
    output logic                                       pslverr_o,
    // peripheral configuration bus
    output logic      [31:0]                           periph_cfg_data_o,
    output logic      [udma_pkg::OFFSET_WIDTH-1:0]     periph_cfg_addr_o,
    output logic                                       periph_cfg_rwn_o,
    output logic      [N_PERIPHS-1:0]                  periph_cfg_valid_o,
    input  wire logic [N_PERIPHS-1:0]                  periph_cfg_ready_i,
    input  wire logic [N_PERIPHS-1:0][31:0]            periph_cfg_rdata_i,
    // global control block
    output logic                                       ctrl_wr_o,
    output logic      [udma_pkg::OFFSET_WIDTH-1:0]     ctrl_offset_o,
    output logic      [31:0]                           ctrl_wdata_o,
    input  wire logic [31:0]                           ctrl_rdata_i
);

    logic [udma_pkg::ID_WIDTH-1:0]     target;
    logic [udma_pkg::OFFSET_WIDTH-1:0] offset;
    logic                              access;
    logic                              first_access;
    logic                              busy_q;
    logic                              is_periph;
    logic                              is_ctrl;
    logic                              sel_ready;
    logic [31:0]                       sel_rdata;

    assign target = paddr_i[udma_pkg::ID_LSB +: udma_pkg::ID_WIDTH];
    assign offset = paddr_i[udma_pkg::ID_LSB-udma_pkg::OFFSET_WIDTH +: udma_pkg::OFFSET_WIDTH];
    assign access = psel_i & penable_i;

    assign is_periph = int'(target) < N_PERIPHS;
    assign is_ctrl   = target == udma_pkg::CTRL_ID;

    // high while an access phase waits for a slow peripheral
    always_ff @(posedge sys_clk_i) begin
        if (!rst_n_i) begin
            busy_q <= 1'b0;
        end else begin
            busy_q <= access & ~pready_o;
        end
    end

    assign first_access = access & ~busy_q;

    // per-peripheral valid plus ready/rdata select
    always_comb begin
        periph_cfg_valid_o = '0;
        sel_ready          = 1'b0;
        sel_rdata          = '0;
        for (int i = 0; i < N_PERIPHS; i++) begin
            if (int'(target) == i) begin
                periph_cfg_valid_o[i] = access;
                sel_ready             = periph_cfg_ready_i[i];
                sel_rdata             = periph_cfg_rdata_i[i];
            end
        end
    end

    assign periph_cfg_addr_o = offset;
    assign periph_cfg_data_o = pwdata_i;
    assign periph_cfg_rwn_o  = ~pwrite_i;

    // control registers take the write only once per transfer
    assign ctrl_wr_o     = first_access & is_ctrl & pwrite_i;
    assign ctrl_offset_o = offset;
    assign ctrl_wdata_o  = pwdata_i;

    // control and unmapped targets finish in the first access cycle
    assign pready_o  = is_periph ? (access & sel_ready) : first_access;
    assign pslverr_o = first_access & ~is_periph & ~is_ctrl;

    always_comb begin
        if (is_periph) begin
            prdata_o = sel_rdata;
        end else if (is_ctrl) begin
            prdata_o = ctrl_rdata_i;
        end else begin
            prdata_o = '0;
        end
    end

endmodule

`default_nettype wire

//--- rtl/udma_ctrl_regs.sv
// Global control registers holding peripheral clock enables and the trigger event IDs
`timescale 1ns/1ps
`default_nettype none

module udma_ctrl_regs #(
    parameter int N_PERIPHS = 6
) (
    input  wire logic                                sys_clk_i,
    input  wire logic                                rst_n_i,
    // write port from the APB decoder
    input  wire logic                                ctrl_wr_i,
    input  wire logic [udma_pkg::OFFSET_WIDTH-1:0]   ctrl_offset_i,
    input  wire logic [31:0]                         ctrl_wdata_i,
    output logic      [31:0]                         ctrl_rdata_o,
    // register contents
    output logic      [N_PERIPHS-1:0]                periph_clk_en_o,
    output logic      [udma_pkg::N_TRIGGERS-1:0][udma_pkg::EVT_ID_WIDTH-1:0] trig_id_o
);

    logic [N_PERIPHS-1:0] clk_en_q;
    logic [udma_pkg::N_TRIGGERS-1:0][udma_pkg::EVT_ID_WIDTH-1:0] trig_id_q;

    // register writes decoded by word offset
    always_ff @(posedge sys_clk_i) begin
        if (!rst_n_i) begin
            clk_en_q  <= '0;
            trig_id_q <= '0;
        end else if (ctrl_wr_i) begin
            case (ctrl_offset_i)
                udma_pkg::REG_CLK_EN: begin
                    clk_en_q <= ctrl_wdata_i[N_PERIPHS-1:0];
                end
                udma_pkg::REG_TRIG_ID: begin
                    trig_id_q <= ctrl_wdata_i;
                end
                default: begin
                    // writes to other offsets are dropped
                end
            endcase
        end
    end

    // read mux sees the old value during a write cycle
    always_comb begin
        case (ctrl_offset_i)
            udma_pkg::REG_CLK_EN: begin
                ctrl_rdata_o = 32'(clk_en_q);
            end
            udma_pkg::REG_TRIG_ID: begin
                ctrl_rdata_o = trig_id_q;
            end
            default: begin
                ctrl_rdata_o = '0;
            end
        endcase
    end

    assign periph_clk_en_o = clk_en_q;
    assign trig_id_o       = trig_id_q;

endmodule

`default_nettype wire

//--- rtl/udma_event_trigger.sv
// Matches incoming event numbers against the trigger IDs and emits one-cycle trigger pulses
`timescale 1ns/1ps
`default_nettype none

module udma_event_trigger (
    input  wire logic                                  sys_clk_i,
    input  wire logic                                  rst_n_i,
    // event input port
    input  wire logic                                  event_valid_i,
    input  wire logic [udma_pkg::EVT_ID_WIDTH-1:0]     event_data_i,
    output logic                                       event_ready_o,
    // configured IDs and trigger pulses
    input  wire logic [udma_pkg::N_TRIGGERS-1:0][udma_pkg::EVT_ID_WIDTH-1:0] trig_id_i,
    output logic      [udma_pkg::N_TRIGGERS-1:0]       triggers_o
);

    logic                            ready_q;
    logic                            accept;
    logic [udma_pkg::N_TRIGGERS-1:0] match;
    logic [udma_pkg::N_TRIGGERS-1:0] triggers_q;

    // no back-pressure once out of reset
    always_ff @(posedge sys_clk_i) begin
        if (!rst_n_i) begin
            ready_q <= 1'b0;
        end else begin
            ready_q <= 1'b1;
        end
    end

    assign accept = event_valid_i & ready_q;

    always_comb begin
        for (int k = 0; k < udma_pkg::N_TRIGGERS; k++) begin
            match[k] = accept & (event_data_i == trig_id_i[k]);
        end
    end

    // pulse lasts the single cycle after acceptance
    always_ff @(posedge sys_clk_i) begin
        if (!rst_n_i) begin
            triggers_q <= '0;
        end else begin
            triggers_q <= match;
        end
    end

    assign event_ready_o = ready_q;
    assign triggers_o    = triggers_q;

endmodule

`default_nettype wire

//--- rtl/udma_subsystem.sv
// Top level of the micro-DMA control plane; peripherals attach at the loose config ports
`timescale 1ns/1ps
`default_nettype none

module udma_subsystem #(
    parameter int N_PERIPHS = 6
) (
    input  wire logic                                  sys_clk_i,
    input  wire logic                                  rst_n_i,
    // APB slave
    input  wire logic [udma_pkg::APB_ADDR_WIDTH-1:0]   paddr_i,
    input  wire logic [31:0]                           pwdata_i,
    input  wire logic                                  pwrite_i,
    input  wire logic                                  psel_i,
    input  wire logic                                  penable_i,
    output logic      [31:0]                           prdata_o,
    output logic                                       pready_o,
    output logic                                       pslverr_o,
    // event input and triggers
    input  wire logic                                  event_valid_i,
    input  wire logic [udma_pkg::EVT_ID_WIDTH-1:0]     event_data_i,
    output logic                                       event_ready_o,
    output logic      [udma_pkg::N_TRIGGERS-1:0]       triggers_o,
    // peripheral side
    output logic      [N_PERIPHS-1:0]                  periph_clk_en_o,
    output logic      [31:0]                           periph_cfg_data_o,
    output logic      [udma_pkg::OFFSET_WIDTH-1:0]     periph_cfg_addr_o,
    output logic                                       periph_cfg_rwn_o,
    output logic      [N_PERIPHS-1:0]                  periph_cfg_valid_o,
    input  wire logic [N_PERIPHS-1:0]                  periph_cfg_ready_i,
    input  wire logic [N_PERIPHS-1:0][31:0]            periph_cfg_rdata_i,
    input  wire logic [N_PERIPHS-1:0][udma_pkg::EVT_WIDTH-1:0] periph_events_i,
    output logic      [udma_pkg::N_EVT_SLOTS-1:0][udma_pkg::EVT_WIDTH-1:0] events_o
);

    logic                                                       s_ctrl_wr;
    logic [udma_pkg::OFFSET_WIDTH-1:0]                          s_ctrl_offset;
    logic [31:0]                                                s_ctrl_wdata;
    logic [31:0]                                                s_ctrl_rdata;
    logic [udma_pkg::N_TRIGGERS-1:0][udma_pkg::EVT_ID_WIDTH-1:0] s_trig_id;

    udma_apb_decoder #(
        .N_PERIPHS          ( N_PERIPHS          )
    ) i_apb_decoder (
        .sys_clk_i          ( sys_clk_i          ),
        .rst_n_i            ( rst_n_i            ),
        .paddr_i            ( paddr_i            ),
        .pwdata_i           ( pwdata_i           ),
        .pwrite_i           ( pwrite_i           ),
        .psel_i             ( psel_i             ),
        .penable_i          ( penable_i          ),
        .prdata_o           ( prdata_o           ),
        .pready_o           ( pready_o           ),
        .pslverr_o          ( pslverr_o          ),
        .periph_cfg_data_o  ( periph_cfg_data_o  ),
        .periph_cfg_addr_o  ( periph_cfg_addr_o  ),
        .periph_cfg_rwn_o   ( periph_cfg_rwn_o   ),
        .periph_cfg_valid_o ( periph_cfg_valid_o ),
        .periph_cfg_ready_i ( periph_cfg_ready_i ),
        .periph_cfg_rdata_i ( periph_cfg_rdata_i ),
        .ctrl_wr_o          ( s_ctrl_wr          ),
        .ctrl_offset_o      ( s_ctrl_offset      ),
        .ctrl_wdata_o       ( s_ctrl_wdata       ),
        .ctrl_rdata_i       ( s_ctrl_rdata       )
    );

    udma_ctrl_regs #(
        .N_PERIPHS       ( N_PERIPHS       )
    ) i_ctrl_regs (
        .sys_clk_i       ( sys_clk_i       ),
        .rst_n_i         ( rst_n_i         ),
        .ctrl_wr_i       ( s_ctrl_wr       ),
        .ctrl_offset_i   ( s_ctrl_offset   ),
        .ctrl_wdata_i    ( s_ctrl_wdata    ),
        .ctrl_rdata_o    ( s_ctrl_rdata    ),
        .periph_clk_en_o ( periph_clk_en_o ),
        .trig_id_o       ( s_trig_id       )
    );

    udma_event_trigger i_event_trigger (
        .sys_clk_i     ( sys_clk_i     ),
        .rst_n_i       ( rst_n_i       ),
        .event_valid_i ( event_valid_i ),
        .event_data_i  ( event_data_i  ),
        .event_ready_o ( event_ready_o ),
        .trig_id_i     ( s_trig_id     ),
        .triggers_o    ( triggers_o    )
    );

    // slots past the last peripheral read zero
    for (genvar i = 0; i < udma_pkg::N_EVT_SLOTS; i++) begin : gen_evt_bus
        if (i < N_PERIPHS) begin : gen_used
            assign events_o[i] = periph_events_i[i];
        end else begin : gen_unused
            assign events_o[i] = '0;
        end
    end

endmodule

`default_nettype wire

//--- tests/udma_checker.sv
// Watches the DUT ports, keeps reference models of registers and triggers, reports per test
`timescale 1ns/1ps
`default_nettype none

module udma_checker #(
    parameter int N_PERIPHS = 6
) (
    input  wire logic                                    sys_clk_i,
    input  wire logic                                    rst_n_i,
    // APB as seen at the DUT
    input  wire logic [udma_pkg::APB_ADDR_WIDTH-1:0]     paddr_i,
    input  wire logic [31:0]                             pwdata_i,
    input  wire logic                                    pwrite_i,
    input  wire logic                                    psel_i,
    input  wire logic                                    penable_i,
    input  wire logic [31:0]                             prdata_i,
    input  wire logic                                    pready_i,
    input  wire logic                                    pslverr_i,
    // events, triggers and peripheral side
    input  wire logic                                    event_valid_i,
    input  wire logic [udma_pkg::EVT_ID_WIDTH-1:0]       event_data_i,
    input  wire logic                                    event_ready_i,
    input  wire logic [udma_pkg::N_TRIGGERS-1:0]         triggers_i,
    input  wire logic [N_PERIPHS-1:0]                    clk_en_i,
    input  wire logic [N_PERIPHS-1:0]                    cfg_valid_i,
    input  wire logic [N_PERIPHS-1:0][3:0]               periph_events_i,
    input  wire logic [udma_pkg::N_EVT_SLOTS-1:0][3:0]   events_i,
    // test bookkeeping from the testbench top
    input  wire logic [3:0]                              test_idx_i,
    input  wire logic                                    test_end_i,
    output int                                           err_count_o
);

    logic [31:0]          mem_m [32][32];
    logic                 written_m [32][32];
    logic [N_PERIPHS-1:0] clk_en_m;
    logic [31:0]          trig_m;
    logic [3:0]           exp_trig;
    int                   test_errs;

    initial begin
        for (int i = 0; i < 32; i++) begin
            for (int j = 0; j < 32; j++) begin
                mem_m[i][j]     = 32'h0;
                written_m[i][j] = 1'b0;
            end
        end
        clk_en_m    = '0;
        trig_m      = 32'h0;
        exp_trig    = 4'h0;
        test_errs   = 0;
        err_count_o = 0;
    end

    function automatic string test_name(input logic [3:0] idx);
        case (idx)
            4'd0:    return "reset_state";
            4'd1:    return "periph_round_trip";
            4'd2:    return "ctrl_regs";
            4'd3:    return "unmapped_target";
            4'd4:    return "trigger_match";
            4'd5:    return "event_bus";
            default: return "unknown";
        endcase
    endfunction

    // expected read data of any APB target
    function automatic logic [31:0] ref_apb_read(input logic [4:0] id, input logic [4:0] off);
        if (int'(id) < N_PERIPHS) return mem_m[id][off];
        if (id != udma_pkg::CTRL_ID) return 32'h0;
        if (off == udma_pkg::REG_CLK_EN) return 32'(clk_en_m);
        if (off == udma_pkg::REG_TRIG_ID) return trig_m;
        return 32'h0;
    endfunction

    // one bit per trigger whose byte in the ID word equals the event
    function automatic logic [3:0] ref_triggers(input logic [7:0] evt, input logic [31:0] ids);
        return {ids[31:24] == evt, ids[23:16] == evt, ids[15:8] == evt, ids[7:0] == evt};
    endfunction

    // unused slots are zero
    function automatic logic [3:0] ref_event_slot(input logic [4:0] slot);
        logic [udma_pkg::N_EVT_SLOTS*4-1:0] flat;
        flat = '0;
        flat[N_PERIPHS*4-1:0] = periph_events_i;
        return flat[{slot, 2'b00} +: 4];
    endfunction

    task automatic model_write(input logic [4:0] id, input logic [4:0] off, input logic [31:0] d);
        if (int'(id) < N_PERIPHS) begin
            mem_m[id][off]     = d;
            written_m[id][off] = 1'b1;
        end else if (id == udma_pkg::CTRL_ID) begin
            if (off == udma_pkg::REG_CLK_EN) begin
                clk_en_m = d[N_PERIPHS-1:0];
            end else if (off == udma_pkg::REG_TRIG_ID) begin
                trig_m = d;
            end
        end
    endtask

    task automatic flag_mismatch(input string what, input logic [31:0] exp,
                                 input logic [31:0] act);
        $display("ERROR %s %s: expected 0x%08h actual 0x%08h",
                 test_name(test_idx_i), what, exp, act);
        err_count_o++;
        test_errs++;
    endtask

    // a completing APB transfer shows pready high at mid-cycle
    always @(negedge sys_clk_i) begin
        logic [4:0] id;
        logic [4:0] off;
        logic       is_periph;
        logic       mapped;
        logic [3:0] slot_exp;
        id        = paddr_i[udma_pkg::ID_LSB +: udma_pkg::ID_WIDTH];
        off       = paddr_i[6:2];
        is_periph = int'(id) < N_PERIPHS;
        mapped    = is_periph || (id == udma_pkg::CTRL_ID);
        if (rst_n_i) begin
            if (clk_en_i != clk_en_m) begin
                flag_mismatch("periph_clk_en_o", 32'(clk_en_m), 32'(clk_en_i));
            end
            for (int i = 0; i < udma_pkg::N_EVT_SLOTS; i++) begin
                slot_exp = ref_event_slot(5'(i));
                if (events_i[5'(i)] != slot_exp) begin
                    flag_mismatch($sformatf("events_o slot %0d", i), 32'(slot_exp),
                                  32'(events_i[5'(i)]));
                end
            end
            if (triggers_i != exp_trig) begin
                flag_mismatch("triggers_o", 32'(exp_trig), 32'(triggers_i));
            end
            // an event taken at the next edge pulses one cycle later
            if (event_valid_i) begin
                exp_trig = ref_triggers(event_data_i, trig_m);
            end else begin
                exp_trig = 4'h0;
            end
            if (psel_i && penable_i && !mapped && cfg_valid_i != '0) begin
                flag_mismatch("periph_cfg_valid_o", 32'h0, 32'(cfg_valid_i));
            end
            if (psel_i && penable_i && pready_i) begin
                if (pslverr_i != !mapped) begin
                    flag_mismatch("pslverr_o", 32'(!mapped), 32'(pslverr_i));
                end
                if (pwrite_i) begin
                    model_write(id, off, pwdata_i);
                end else if (!is_periph || written_m[id][off]) begin
                    if (prdata_i != ref_apb_read(id, off)) begin
                        flag_mismatch("prdata_o", ref_apb_read(id, off), prdata_i);
                    end
                end
            end
            if (test_end_i) begin
                if (test_idx_i == 4'd0) begin
                    if (event_ready_i !== 1'b1) begin
                        flag_mismatch("event_ready_o", 32'h1, 32'(event_ready_i));
                    end
                    if (cfg_valid_i != '0) begin
                        flag_mismatch("periph_cfg_valid_o", 32'h0, 32'(cfg_valid_i));
                    end
                end
                $display("test %s finished: %0d errors", test_name(test_idx_i), test_errs);
                test_errs = 0;
            end
        end
    end

endmodule

`default_nettype wire

//--- tests/tb_udma_subsystem.sv
// Testbench top with clock, reset, APB and event stimulus, peripheral models and the verdict
`timescale 1ns/1ps
`default_nettype none

module tb_udma_subsystem;

    localparam int N_PERIPHS      = 6;
    localparam int PREADY_TIMEOUT = 20;
    localparam int TRIG_TIMEOUT   = 4;

    logic                        clk;
    logic                        rst_n;
    logic [11:0]                 paddr;
    logic [31:0]                 pwdata;
    logic                        pwrite;
    logic                        psel;
    logic                        penable;
    logic [31:0]                 prdata;
    logic                        pready;
    logic                        pslverr;
    logic                        event_valid;
    logic [7:0]                  event_data;
    logic                        event_ready;
    logic [3:0]                  triggers;
    logic [N_PERIPHS-1:0]        clk_en;
    logic [31:0]                 cfg_data;
    logic [4:0]                  cfg_addr;
    logic                        cfg_rwn;
    logic [N_PERIPHS-1:0]        cfg_valid;
    logic [N_PERIPHS-1:0]        cfg_ready = '0;
    logic [N_PERIPHS-1:0][31:0]  cfg_rdata = '0;
    logic [N_PERIPHS-1:0][3:0]   periph_events;
    logic [31:0][3:0]            events;
    logic [3:0]                  test_idx;
    logic                        test_end;
    int                          chk_errors;
    int                          timeouts;
    logic [31:0]                 regs [N_PERIPHS][32];
    int                          delay_cnt [N_PERIPHS];
    logic [4:0]                  wr_ids [$];
    logic [4:0]                  wr_offs [$];

    initial clk = 1'b0;
    always #20 clk = ~clk;

    udma_subsystem #(.N_PERIPHS(N_PERIPHS)) i_dut (
        .sys_clk_i(clk), .rst_n_i(rst_n),
        .paddr_i(paddr), .pwdata_i(pwdata), .pwrite_i(pwrite), .psel_i(psel),
        .penable_i(penable), .prdata_o(prdata), .pready_o(pready), .pslverr_o(pslverr),
        .event_valid_i(event_valid), .event_data_i(event_data),
        .event_ready_o(event_ready), .triggers_o(triggers), .periph_clk_en_o(clk_en),
        .periph_cfg_data_o(cfg_data), .periph_cfg_addr_o(cfg_addr),
        .periph_cfg_rwn_o(cfg_rwn), .periph_cfg_valid_o(cfg_valid),
        .periph_cfg_ready_i(cfg_ready), .periph_cfg_rdata_i(cfg_rdata),
        .periph_events_i(periph_events), .events_o(events)
    );

    udma_checker #(.N_PERIPHS(N_PERIPHS)) i_checker (
        .sys_clk_i(clk), .rst_n_i(rst_n),
        .paddr_i(paddr), .pwdata_i(pwdata), .pwrite_i(pwrite), .psel_i(psel),
        .penable_i(penable), .prdata_i(prdata), .pready_i(pready), .pslverr_i(pslverr),
        .event_valid_i(event_valid), .event_data_i(event_data),
        .event_ready_i(event_ready), .triggers_i(triggers), .clk_en_i(clk_en),
        .cfg_valid_i(cfg_valid), .periph_events_i(periph_events), .events_i(events),
        .test_idx_i(test_idx), .test_end_i(test_end), .err_count_o(chk_errors)
    );

    // peripheral models with 32 words each and ready after 0 to 3 cycles
    always @(posedge clk) begin
        for (int i = 0; i < N_PERIPHS; i++) begin
            if (!rst_n) begin
                cfg_ready[i] <= 1'b0;
                delay_cnt[i] = int'($urandom_range(3, 0));
                for (int j = 0; j < 32; j++) begin
                    regs[i][j] <= 32'hc0de_0000 | (32'(i) << 8) | 32'(j);
                end
            end else if (cfg_valid[i] && cfg_ready[i]) begin
                cfg_ready[i] <= 1'b0;
                if (!cfg_rwn) regs[i][cfg_addr] <= cfg_data;
                delay_cnt[i] = int'($urandom_range(3, 0));
            end else if (cfg_valid[i]) begin
                if (delay_cnt[i] == 0) begin
                    cfg_ready[i] <= 1'b1;
                    cfg_rdata[i] <= regs[i][cfg_addr];
                end else begin
                    delay_cnt[i] = delay_cnt[i] - 1;
                end
            end
        end
    end

    task automatic apb_access(input logic wr, input logic [4:0] id, input logic [4:0] off,
                              input logic [31:0] data);
        int waited;
        @(posedge clk);
        paddr   <= {id, off, 2'b00};
        pwdata  <= data;
        pwrite  <= wr;
        psel    <= 1'b1;
        penable <= 1'b0;
        @(posedge clk);
        penable <= 1'b1;
        waited = 0;
        @(negedge clk);
        while (!pready && waited < PREADY_TIMEOUT) begin
            @(negedge clk);
            waited++;
        end
        if (!pready) begin
            $display("timeout: target %0d gave no pready_o within %0d cycles", id, waited);
            timeouts++;
        end
        @(posedge clk);
        psel    <= 1'b0;
        penable <= 1'b0;
    endtask

    function automatic logic id_configured(input logic [7:0] evt, input logic [31:0] ids);
        return evt == ids[7:0] || evt == ids[15:8] || evt == ids[23:16] || evt == ids[31:24];
    endfunction

    // half of the events reuse a configured ID
    function automatic logic [7:0] pick_event(input logic [31:0] ids);
        logic [1:0] sel;
        sel = 2'($urandom);
        if ($urandom_range(1, 0) == 0) return 8'($urandom);
        return ids[{sel, 3'b000} +: 8];
    endfunction

    task automatic send_event(input logic [7:0] evt, input logic wait_pulse);
        int waited;
        @(posedge clk);
        event_valid <= 1'b1;
        event_data  <= evt;
        @(posedge clk);
        event_valid <= 1'b0;
        if (wait_pulse) begin
            waited = 0;
            @(negedge clk);
            while (triggers == 4'h0 && waited < TRIG_TIMEOUT) begin
                @(negedge clk);
                waited++;
            end
            if (triggers == 4'h0) begin
                $display("timeout: event 0x%02h raised no trigger pulse", evt);
                timeouts++;
            end
        end
    endtask

    task automatic start_test(input logic [3:0] idx);
        @(posedge clk);
        test_idx <= idx;
    endtask

    task automatic finish_test();
        @(posedge clk);
        test_end <= 1'b1;
        @(posedge clk);
        test_end <= 1'b0;
    endtask

    initial begin
        logic [4:0]  id;
        logic [31:0] ids;
        logic [7:0]  evt;
        int          pick;
        void'($urandom(32'hb49c_3b9e));
        rst_n = 1'b0;
        paddr = '0;
        pwdata = '0;
        pwrite = 1'b0;
        psel = 1'b0;
        penable = 1'b0;
        event_valid = 1'b0;
        event_data = '0;
        periph_events = '0;
        test_idx = 4'd0;
        test_end = 1'b0;
        timeouts = 0;
        repeat (16) @(posedge clk);
        rst_n <= 1'b1;

        start_test(4'd0);
        finish_test();

        start_test(4'd1);
        repeat (40) begin
            id = 5'($urandom_range(N_PERIPHS - 1, 0));
            wr_ids.push_back(id);
            wr_offs.push_back(5'($urandom));
            apb_access(1'b1, id, wr_offs[$], $urandom);
        end
        repeat (40) begin
            pick = int'($urandom_range(wr_ids.size() - 1, 0));
            apb_access(1'b0, wr_ids[pick], wr_offs[pick], 32'h0);
        end
        finish_test();

        start_test(4'd2);
        repeat (4) begin
            apb_access(1'b1, udma_pkg::CTRL_ID, udma_pkg::REG_CLK_EN, $urandom);
            apb_access(1'b0, udma_pkg::CTRL_ID, udma_pkg::REG_CLK_EN, 32'h0);
            apb_access(1'b1, udma_pkg::CTRL_ID, udma_pkg::REG_TRIG_ID, $urandom);
            apb_access(1'b0, udma_pkg::CTRL_ID, udma_pkg::REG_TRIG_ID, 32'h0);
        end
        // unused offset reads zero
        apb_access(1'b0, udma_pkg::CTRL_ID, 5'd2, 32'h0);
        finish_test();

        start_test(4'd3);
        if (N_PERIPHS < 31) begin
            repeat (8) begin
                id = 5'($urandom_range(30, N_PERIPHS));
                apb_access(1'($urandom_range(1, 0)), id, 5'($urandom), $urandom);
            end
        end
        foreach (wr_ids[i]) apb_access(1'b0, wr_ids[i], wr_offs[i], 32'h0);
        finish_test();

        start_test(4'd4);
        ids = $urandom;
        // two triggers share an ID so both fire together
        ids[31:24] = ids[15:8];
        apb_access(1'b1, udma_pkg::CTRL_ID, udma_pkg::REG_TRIG_ID, ids);
        repeat (24) begin
            evt = pick_event(ids);
            send_event(evt, id_configured(evt, ids));
        end
        // back-to-back burst
        repeat (16) begin
            @(posedge clk);
            event_valid <= 1'b1;
            event_data  <= pick_event(ids);
        end
        @(posedge clk);
        event_valid <= 1'b0;
        finish_test();

        start_test(4'd5);
        repeat (10) begin
            @(posedge clk);
            for (int i = 0; i < N_PERIPHS; i++) periph_events[i] <= 4'($urandom);
        end
        @(posedge clk);
        finish_test();

        repeat (2) @(posedge clk);
        $display("summary: 6 tests, %0d check errors, %0d timeouts", chk_errors, timeouts);
        if (chk_errors == 0 && timeouts == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- sim.f
rtl/udma_pkg.sv
rtl/udma_apb_decoder.sv
rtl/udma_ctrl_regs.sv
rtl/udma_event_trigger.sv
rtl/udma_subsystem.sv
tests/udma_checker.sv
tests/tb_udma_subsystem.sv

//--- Makefile
TOP := tb_udma_subsystem

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing -f sim.f --top-module udma_subsystem
	verilator --lint-only --timing -f sim.f --top-module $(TOP)

sim:
	verilator --binary --timing -f sim.f --top-module $(TOP) -o $(TOP)
	./obj_dir/$(TOP) | tee sim.log
	grep -qx "No errors" sim.log

clean:
	rm -rf obj_dir sim.log
